// File: src.f
src/bayer_stats_pkg.sv
src/sensor_framer.sv
src/bayer_accumulator.sv
src/channel_mean_divider.sv
src/bayer_stats_top.sv
testbench/tb_bayer_stats.sv

// File: testbench/tb_bayer_stats.sv
`timescale 1ns/100ps

module tb_bayer_stats;

   localparam int PIXEL_WIDTH    = bayer_stats_pkg::DEF_PIXEL_WIDTH;
   localparam int NUM_ROWS_WIDTH = bayer_stats_pkg::DEF_NUM_ROWS_WIDTH;
   localparam int NUM_COLS_WIDTH = bayer_stats_pkg::DEF_NUM_COLS_WIDTH;
   localparam int ACCUM_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH + PIXEL_WIDTH - 2;
   localparam int COUNT_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH;
   localparam int CLK_PERIOD     = 40;
   localparam int ROW_GAP        = 3;      // idle cycles between lines
   localparam int DONE_TIMEOUT   = 2000;
   localparam int MEAN_TIMEOUT   = 400;
   localparam logic [31:0] LFSR_SEED = 32'h37a67131;

   typedef logic [ACCUM_WIDTH-1:0] sum_t;
   typedef logic [COUNT_WIDTH-1:0] count_t;
   typedef logic [PIXEL_WIDTH-1:0] mean_t;

   logic                      pixclk;
   logic                      resetb;
   logic                      fv;
   logic                      lv;
   mean_t                     pixel_in;
   logic [NUM_ROWS_WIDTH-1:0] row_start;
   logic [NUM_ROWS_WIDTH-1:0] row_end;
   logic [NUM_COLS_WIDTH-1:0] col_start;
   logic [NUM_COLS_WIDTH-1:0] col_end;
   sum_t                      accum00;
   sum_t                      accum01;
   sum_t                      accum10;
   sum_t                      accum11;
   count_t                    accum_count;
   logic                      done;
   logic                      busy;
   mean_t                     mean00;
   mean_t                     mean01;
   mean_t                     mean10;
   mean_t                     mean11;
   logic                      mean_valid;

   logic [31:0] lfsr;
   mean_t       pix [0:15][0:15];   // reference copy of the frame
   int          frame_rows;
   int          frame_cols;
   int          busy_low;
   sum_t        exp_sum [0:3];
   count_t      exp_count;
   mean_t       exp_mean [0:3];
   int          errors;
   int          timeouts;
   int          tests;

   bayer_stats_top #(
      .PIXEL_WIDTH    (PIXEL_WIDTH),
      .NUM_ROWS_WIDTH (NUM_ROWS_WIDTH),
      .NUM_COLS_WIDTH (NUM_COLS_WIDTH)
   ) u_bayer_stats_top (
      .pixclk (pixclk), .resetb (resetb),
      .fv (fv), .lv (lv), .pixel_in (pixel_in),
      .row_start (row_start), .row_end (row_end),
      .col_start (col_start), .col_end (col_end),
      .accum00 (accum00), .accum01 (accum01), .accum10 (accum10), .accum11 (accum11),
      .accum_count (accum_count), .done (done), .busy (busy),
      .mean00 (mean00), .mean01 (mean01), .mean10 (mean10), .mean11 (mean11),
      .mean_valid (mean_valid)
   );

   initial begin
      pixclk = 1'b0;
      forever #(CLK_PERIOD / 2) pixclk = ~pixclk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_pixel(output mean_t p);
      for (int b = 0; b < PIXEL_WIDTH; b++) begin
         lfsr = lfsr_next(lfsr);
         p[b] = lfsr[0];   // one step per bit
      end
   endtask

   task automatic compare_sum(input string what, input sum_t got, input sum_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_count(input string what, input count_t got, input count_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_mean(input string what, input mean_t got, input mean_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic compare_cycles(input string what, input int got, input int exp);
      if (got != exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   // window and parity rules applied to the stored frame
   task automatic model_frame();
      sum_t q;
      for (int i = 0; i < 4; i++) exp_sum[i] = '0;
      exp_count = '0;
      for (int r = 0; r < frame_rows; r++) begin
         for (int c = 0; c < frame_cols; c++) begin
            if (r >= row_start && r < row_end && c >= col_start && c < col_end) begin
               exp_sum[(r % 2) * 2 + (c % 2)] += sum_t'(pix[r][c]);
               if (r % 2 == 0 && c % 2 == 0) exp_count++;
            end
         end
      end
      for (int i = 0; i < 4; i++) begin
         q = (exp_count == 0) ? '0 : exp_sum[i] / sum_t'(exp_count);
         exp_mean[i] = (q > sum_t'({PIXEL_WIDTH{1'b1}})) ? '1 : mean_t'(q);
      end
   endtask

   task automatic drive_frame(input int nrows, input int ncols);
      mean_t p;
      frame_rows = nrows;
      frame_cols = ncols;
      busy_low   = 0;
      fv = 1'b1;
      repeat (3) @(negedge pixclk);
      for (int r = 0; r < nrows; r++) begin
         for (int c = 0; c < ncols; c++) begin
            take_pixel(p);
            pix[r][c] = p;
            lv       = 1'b1;
            pixel_in = p;
            if (busy !== 1'b1) busy_low++;
            @(negedge pixclk);
         end
         lv = 1'b0;
         repeat (ROW_GAP) @(negedge pixclk);
      end
      fv = 1'b0;
      repeat (4) @(negedge pixclk);
   endtask

   task automatic collect_results(input string name);
      int waited;
      int cycles;
      waited = 0;
      while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
         @(negedge pixclk);
         waited++;
      end
      if (done !== 1'b1) begin
         $display("%s: timed out waiting for done after %0d cycles", name, waited);
         timeouts++;
      end else begin
         model_frame();
         @(negedge pixclk);   // holding registers load here
         compare_flag({name, " done one cycle later"}, done, 1'b0);
         compare_flag({name, " busy after done"}, busy, 1'b0);
         compare_sum({name, " accum00"}, accum00, exp_sum[0]);
         compare_sum({name, " accum01"}, accum01, exp_sum[1]);
         compare_sum({name, " accum10"}, accum10, exp_sum[2]);
         compare_sum({name, " accum11"}, accum11, exp_sum[3]);
         compare_count({name, " accum_count"}, accum_count, exp_count);
         cycles = 1;
         while (mean_valid !== 1'b1 && cycles < MEAN_TIMEOUT) begin
            @(negedge pixclk);
            cycles++;
         end
         if (mean_valid !== 1'b1) begin
            $display("%s: timed out waiting for mean_valid after %0d cycles", name, cycles);
            timeouts++;
         end else begin
            compare_cycles({name, " done to mean_valid"}, cycles, 4 * ACCUM_WIDTH + 3);
            compare_mean({name, " mean00"}, mean00, exp_mean[0]);
            compare_mean({name, " mean01"}, mean01, exp_mean[1]);
            compare_mean({name, " mean10"}, mean10, exp_mean[2]);
            compare_mean({name, " mean11"}, mean11, exp_mean[3]);
         end
      end
   endtask

   task automatic run_frame(input string name, input int nrows, input int ncols,
                            input int rs, input int re, input int cs, input int ce);
      row_start = NUM_ROWS_WIDTH'(rs);
      row_end   = NUM_ROWS_WIDTH'(re);
      col_start = NUM_COLS_WIDTH'(cs);
      col_end   = NUM_COLS_WIDTH'(ce);
      fork
         drive_frame(nrows, ncols);
         collect_results(name);
      join
      compare_cycles({name, " busy low during pixels"}, busy_low, 0);
   endtask

   // failures are wrong values plus timeouts
   task automatic end_test(input string name, input int err_before);
      tests++;
      if (errors + timeouts == err_before) $display("test %s: ok", name);
      else $display("test %s: %0d failures", name, errors + timeouts - err_before);
   endtask

   task automatic test_reset_state();
      int e;
      e = errors + timeouts;
      compare_flag("done", done, 1'b0);
      compare_flag("busy", busy, 1'b0);
      compare_flag("mean_valid", mean_valid, 1'b0);
      compare_sum("accum00", accum00, '0);
      compare_sum("accum01", accum01, '0);
      compare_sum("accum10", accum10, '0);
      compare_sum("accum11", accum11, '0);
      compare_count("accum_count", accum_count, '0);
      compare_mean("mean00", mean00, '0);
      compare_mean("mean01", mean01, '0);
      compare_mean("mean10", mean10, '0);
      compare_mean("mean11", mean11, '0);
      end_test("reset_state", e);
   endtask

   task automatic test_full_window();
      int e;
      e = errors + timeouts;
      // 16x10 image, the extra row closes the frame at row_end
      run_frame("full_window", 11, 16, 0, 10, 0, 16);
      end_test("full_window", e);
   endtask

   task automatic test_offset_window();
      int e;
      e = errors + timeouts;
      run_frame("offset_window", 8, 14, 1, 7, 3, 12);
      end_test("offset_window", e);
   endtask

   task automatic test_zero_count();
      int e;
      e = errors + timeouts;
      run_frame("zero_count", 3, 8, 1, 2, 0, 8);   // odd row only
      compare_count("zero_count accum_count", accum_count, '0);
      end_test("zero_count", e);
   endtask

   task automatic test_back_to_back();
      int e;
      e = errors + timeouts;
      run_frame("back_to_back first", 6, 10, 0, 5, 0, 10);
      run_frame("back_to_back second", 6, 10, 0, 5, 0, 10);
      end_test("back_to_back", e);
   endtask

   initial begin
      resetb    = 1'b0;
      fv        = 1'b0;
      lv        = 1'b0;
      pixel_in  = '0;
      row_start = '0;
      row_end   = '0;
      col_start = '0;
      col_end   = '0;
      lfsr      = LFSR_SEED;
      errors    = 0;
      timeouts  = 0;
      tests     = 0;
      repeat (2) @(negedge pixclk);
      resetb = 1'b1;
      repeat (2) @(negedge pixclk);
      test_reset_state();
      test_full_window();
      test_offset_window();
      test_zero_count();
      test_back_to_back();
      $display("tests %0d, errors %0d, timeouts %0d", tests, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: src/bayer_stats_top.sv
`timescale 1ns/100ps

module bayer_stats_top #(
   parameter  PIXEL_WIDTH    = bayer_stats_pkg::DEF_PIXEL_WIDTH,
   parameter  NUM_ROWS_WIDTH = bayer_stats_pkg::DEF_NUM_ROWS_WIDTH,
   parameter  NUM_COLS_WIDTH = bayer_stats_pkg::DEF_NUM_COLS_WIDTH,
   localparam ACCUM_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH + PIXEL_WIDTH - 2,
   localparam COUNT_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH
) (
   input  logic                      pixclk,
   input  logic                      resetb,

   input  logic                      fv,
   input  logic                      lv,
   input  logic [PIXEL_WIDTH-1:0]    pixel_in,

   input  logic [NUM_ROWS_WIDTH-1:0] row_start,
   input  logic [NUM_ROWS_WIDTH-1:0] row_end,
   input  logic [NUM_COLS_WIDTH-1:0] col_start,
   input  logic [NUM_COLS_WIDTH-1:0] col_end,

   output logic [ACCUM_WIDTH-1:0]    accum00,
   output logic [ACCUM_WIDTH-1:0]    accum01,
   output logic [ACCUM_WIDTH-1:0]    accum10,
   output logic [ACCUM_WIDTH-1:0]    accum11,
   output logic [COUNT_WIDTH-1:0]    accum_count,
   output logic                      done,
   output logic                      busy,

   output logic [PIXEL_WIDTH-1:0]    mean00,
   output logic [PIXEL_WIDTH-1:0]    mean01,
   output logic [PIXEL_WIDTH-1:0]    mean10,
   output logic [PIXEL_WIDTH-1:0]    mean11,
   output logic                      mean_valid
);

   // token stream from the framer
   logic                    tok_dv;
   bayer_stats_pkg::dtype_t tok_dtype;
   logic [PIXEL_WIDTH-1:0]  tok_data;

   sensor_framer #(
      .PIXEL_WIDTH (PIXEL_WIDTH)
   ) u_sensor_framer (
      .pixclk   (pixclk),
      .resetb   (resetb),
      .fv       (fv),
      .lv       (lv),
      .pixel_in (pixel_in),
      .dv       (tok_dv),
      .dtype    (tok_dtype),
      .data     (tok_data)
   );

   bayer_accumulator #(
      .PIXEL_WIDTH    (PIXEL_WIDTH),
      .NUM_ROWS_WIDTH (NUM_ROWS_WIDTH),
      .NUM_COLS_WIDTH (NUM_COLS_WIDTH)
   ) u_bayer_accumulator (
      .pixclk      (pixclk),
      .resetb      (resetb),
      .dvi         (tok_dv),
      .dtypei      (tok_dtype),
      .datai       (tok_data),
      .row_start   (row_start),
      .row_end     (row_end),
      .col_start   (col_start),
      .col_end     (col_end),
      .accum00     (accum00),
      .accum01     (accum01),
      .accum10     (accum10),
      .accum11     (accum11),
      .accum_count (accum_count),
      .done        (done),
      .busy        (busy)
   );

   // done doubles as the divider start, sums settle one cycle later
   channel_mean_divider #(
      .PIXEL_WIDTH    (PIXEL_WIDTH),
      .NUM_ROWS_WIDTH (NUM_ROWS_WIDTH),
      .NUM_COLS_WIDTH (NUM_COLS_WIDTH)
   ) u_channel_mean_divider (
      .pixclk     (pixclk),
      .resetb     (resetb),
      .start      (done),
      .sum00      (accum00),
      .sum01      (accum01),
      .sum10      (accum10),
      .sum11      (accum11),
      .count      (accum_count),
      .mean00     (mean00),
      .mean01     (mean01),
      .mean10     (mean10),
      .mean11     (mean11),
      .mean_valid (mean_valid)
   );

endmodule

// File: src/channel_mean_divider.sv
`timescale 1ns/100ps

module channel_mean_divider #(
   parameter  PIXEL_WIDTH    = bayer_stats_pkg::DEF_PIXEL_WIDTH,
   parameter  NUM_ROWS_WIDTH = bayer_stats_pkg::DEF_NUM_ROWS_WIDTH,
   parameter  NUM_COLS_WIDTH = bayer_stats_pkg::DEF_NUM_COLS_WIDTH,
   localparam ACCUM_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH + PIXEL_WIDTH - 2,
   localparam COUNT_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH
) (
   input  logic                   pixclk,
   input  logic                   resetb,

   input  logic                   start,
   input  logic [ACCUM_WIDTH-1:0] sum00,
   input  logic [ACCUM_WIDTH-1:0] sum01,
   input  logic [ACCUM_WIDTH-1:0] sum10,
   input  logic [ACCUM_WIDTH-1:0] sum11,
   input  logic [COUNT_WIDTH-1:0] count,

   output logic [PIXEL_WIDTH-1:0] mean00,
   output logic [PIXEL_WIDTH-1:0] mean01,
   output logic [PIXEL_WIDTH-1:0] mean10,
   output logic [PIXEL_WIDTH-1:0] mean11,
   output logic                   mean_valid
);

   localparam ITER_WIDTH = $clog2(ACCUM_WIDTH);

   typedef logic [ACCUM_WIDTH-1:0] accum_t;
   typedef logic [COUNT_WIDTH-1:0] count_t;
   typedef logic [PIXEL_WIDTH-1:0] pixel_t;
   typedef enum logic [1:0] {IDLE, LOAD, DIVIDE, OUTPUT} state_t;

   state_t                state;
   logic [1:0]            chan;
   logic [ITER_WIDTH-1:0] iter;
   logic                  last_iter;
   accum_t                sum_q [1:3];   // channel 00 goes straight into quo
   count_t                count_q;
   accum_t                quo;            // dividend shifts out, quotient shifts in
   count_t                rem;
   logic [COUNT_WIDTH:0]  trial;
   logic                  fits;
   accum_t                quo_next;
   count_t                rem_next;
   pixel_t                mean_r [0:3];

   // zero divisor gives zero, anything above full scale clips
   function automatic pixel_t saturate(input accum_t q, input logic zero_div);
      if (zero_div) begin
         return '0;
      end
      if (|q[ACCUM_WIDTH-1:PIXEL_WIDTH]) begin
         return '1;
      end
      return q[PIXEL_WIDTH-1:0];
   endfunction

   // one restoring step
   assign trial     = {rem, quo[ACCUM_WIDTH-1]};
   assign fits      = trial >= {1'b0, count_q};
   assign quo_next  = {quo[ACCUM_WIDTH-2:0], fits};
   assign rem_next  = fits ? count_t'(trial - {1'b0, count_q}) : trial[COUNT_WIDTH-1:0];
   assign last_iter = (iter == ITER_WIDTH'(ACCUM_WIDTH - 1));

   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         state <= IDLE;
         chan  <= '0;
         iter  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin   // a start while busy is simply missed
                  state <= LOAD;
               end
            end
            LOAD: begin
               chan  <= '0;
               iter  <= '0;
               state <= DIVIDE;
            end
            DIVIDE: begin
               if (last_iter) begin
                  iter <= '0;
                  if (chan == 2'd3) begin
                     state <= OUTPUT;
                  end else begin
                     chan <= chan + 1'b1;
                  end
               end else begin
                  iter <= iter + 1'b1;
               end
            end
            OUTPUT:  state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge pixclk) begin
      case (state)
         LOAD: begin
            sum_q[1] <= sum01;
            sum_q[2] <= sum10;
            sum_q[3] <= sum11;
            count_q  <= count;
            quo      <= sum00;
            rem      <= '0;
         end
         DIVIDE: begin
            if (last_iter) begin
               mean_r[chan] <= saturate(quo_next, count_q == '0);
               rem          <= '0;
               if (chan != 2'd3) begin
                  quo <= sum_q[chan + 1'b1];   // next channel starts fresh
               end
            end else begin
               quo <= quo_next;
               rem <= rem_next;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         mean_valid <= 1'b0;
         mean00     <= '0;
         mean01     <= '0;
         mean10     <= '0;
         mean11     <= '0;
      end else begin
         mean_valid <= (state == OUTPUT);
         if (state == OUTPUT) begin
            mean00 <= mean_r[0];
            mean01 <= mean_r[1];
            mean10 <= mean_r[2];
            mean11 <= mean_r[3];
         end
      end
   end

endmodule

// File: src/bayer_accumulator.sv
`timescale 1ns/100ps

module bayer_accumulator #(
   parameter  PIXEL_WIDTH    = bayer_stats_pkg::DEF_PIXEL_WIDTH,
   parameter  NUM_ROWS_WIDTH = bayer_stats_pkg::DEF_NUM_ROWS_WIDTH,
   parameter  NUM_COLS_WIDTH = bayer_stats_pkg::DEF_NUM_COLS_WIDTH,
   localparam ACCUM_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH + PIXEL_WIDTH - 2,
   localparam COUNT_WIDTH    = NUM_ROWS_WIDTH + NUM_COLS_WIDTH
) (
   input  logic                      pixclk,
   input  logic                      resetb,

   input  logic                      dvi,
   input  bayer_stats_pkg::dtype_t   dtypei,
   input  logic [PIXEL_WIDTH-1:0]    datai,

   input  logic [NUM_ROWS_WIDTH-1:0] row_start,
   input  logic [NUM_ROWS_WIDTH-1:0] row_end,
   input  logic [NUM_COLS_WIDTH-1:0] col_start,
   input  logic [NUM_COLS_WIDTH-1:0] col_end,

   output logic [ACCUM_WIDTH-1:0]    accum00,
   output logic [ACCUM_WIDTH-1:0]    accum01,
   output logic [ACCUM_WIDTH-1:0]    accum10,
   output logic [ACCUM_WIDTH-1:0]    accum11,
   output logic [COUNT_WIDTH-1:0]    accum_count,

   output logic                      done,
   output logic                      busy
);

   typedef logic [ACCUM_WIDTH-1:0]    accum_t;
   typedef logic [COUNT_WIDTH-1:0]    count_t;
   typedef logic [NUM_ROWS_WIDTH-1:0] row_t;
   typedef logic [NUM_COLS_WIDTH-1:0] col_t;

   accum_t     sum_r [0:3];   // running sums, index is {row[0], col[0]}
   count_t     pix_count;
   row_t       row;
   col_t       col;
   logic [1:0] chan;
   logic       in_window;
   logic       is_start;
   logic       is_pixel;
   logic       is_row_end;
   accum_t     pixel_ext;

   assign is_start   = dvi && (dtypei == bayer_stats_pkg::DTYPE_FRAME_START);
   assign is_pixel   = dvi && (dtypei == bayer_stats_pkg::DTYPE_PIXEL);
   assign is_row_end = dvi && (dtypei == bayer_stats_pkg::DTYPE_ROW_END);

   assign chan      = {row[0], col[0]};
   assign pixel_ext = accum_t'(datai);
   // upper bounds are exclusive
   assign in_window = (row >= row_start) && (row < row_end) &&
                      (col >= col_start) && (col < col_end);

   // position counters and the channel 00 pixel count
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         row       <= '0;
         col       <= '0;
         pix_count <= '0;
      end else if (is_start) begin
         row       <= '0;
         col       <= '0;
         pix_count <= '0;
      end else if (is_row_end) begin
         row <= row + 1'b1;
         col <= '0;
      end else if (is_pixel) begin
         col <= col + 1'b1;
         if (in_window && (chan == 2'b00)) begin
            pix_count <= pix_count + 1'b1;
         end
      end
   end

   always_ff @(posedge pixclk) begin
      if (is_start) begin
         for (int i = 0; i < 4; i++) begin
            sum_r[i] <= '0;
         end
      end else if (is_pixel && in_window) begin
         sum_r[chan] <= sum_r[chan] + pixel_ext;
      end
   end

   // done fires when the end row closes, busy spans start to done
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         done <= 1'b0;
         busy <= 1'b0;
      end else begin
         done <= is_row_end && (row == row_end);
         if (is_start) begin
            busy <= 1'b1;
         end else if (done) begin
            busy <= 1'b0;
         end
      end
   end

   // holding outputs keep the last complete frame
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         accum00     <= '0;
         accum01     <= '0;
         accum10     <= '0;
         accum11     <= '0;
         accum_count <= '0;
      end else if (done) begin
         accum00     <= sum_r[0];
         accum01     <= sum_r[1];
         accum10     <= sum_r[2];
         accum11     <= sum_r[3];
         accum_count <= pix_count;
      end
   end

endmodule

// File: src/sensor_framer.sv
`timescale 1ns/100ps

module sensor_framer #(
   parameter PIXEL_WIDTH = bayer_stats_pkg::DEF_PIXEL_WIDTH
) (
   input  logic                    pixclk,
   input  logic                    resetb,

   input  logic                    fv,
   input  logic                    lv,
   input  logic [PIXEL_WIDTH-1:0]  pixel_in,

   output logic                    dv,
   output bayer_stats_pkg::dtype_t dtype,
   output logic [PIXEL_WIDTH-1:0]  data
);

   logic fv_q;
   logic lv_q;
   logic frame_rise;
   logic line_fall;
   logic pixel_on;

   // edges are seen against the previous cycle's levels
   assign frame_rise = fv & ~fv_q;
   assign line_fall  = fv & lv_q & ~lv;   // only counts inside a frame
   assign pixel_on   = fv & lv;

   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         fv_q <= 1'b0;
         lv_q <= 1'b0;
      end else begin
         fv_q <= fv;
         lv_q <= lv;
      end
   end

   // one token per cycle, frame start wins over a pixel on the same cycle
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         dv    <= 1'b0;
         dtype <= bayer_stats_pkg::DTYPE_IDLE;
      end else if (frame_rise) begin
         dv    <= 1'b1;
         dtype <= bayer_stats_pkg::DTYPE_FRAME_START;
      end else if (pixel_on) begin
         dv    <= 1'b1;
         dtype <= bayer_stats_pkg::DTYPE_PIXEL;
      end else if (line_fall) begin
         dv    <= 1'b1;
         dtype <= bayer_stats_pkg::DTYPE_ROW_END;
      end else begin
         dv    <= 1'b0;
         dtype <= bayer_stats_pkg::DTYPE_IDLE;
      end
   end

   // sample register, only meaningful while the tag says pixel
   always_ff @(posedge pixclk) begin
      if (pixel_on) begin
         data <= pixel_in;
      end
   end

endmodule

// File: src/bayer_stats_pkg.sv
package bayer_stats_pkg;

   // token tag carried alongside every framer output
   localparam int DTYPE_WIDTH = 2;

   typedef logic [DTYPE_WIDTH-1:0] dtype_t;

   // token codes
   localparam dtype_t DTYPE_IDLE        = 2'd0;  // nothing on the stream, dv low
   localparam dtype_t DTYPE_FRAME_START = 2'd1;  // first token of a frame
   localparam dtype_t DTYPE_PIXEL       = 2'd2;  // data holds one sample
   localparam dtype_t DTYPE_ROW_END     = 2'd3;  // line just finished

   // default widths, picked up by the top level
   localparam int DEF_PIXEL_WIDTH    = 8;
   localparam int DEF_NUM_ROWS_WIDTH = 12;
   localparam int DEF_NUM_COLS_WIDTH = 12;

endpackage
